// ==== source/synth_pkg.sv ====
// Widths, sample type, MIDI codes, note base table and FIR coefficients
package synth_pkg;

    localparam int SAMPLE_W   = 18;
    localparam int NOTE_W     = 7;
    localparam int VEL_W      = 7;
    localparam int PERIOD_W   = 24;
    localparam int MIDI_CMD_W = 4;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    localparam logic [MIDI_CMD_W-1:0] MIDI_NOTE_ON  = 4'h9;
    localparam logic [MIDI_CMD_W-1:0] MIDI_NOTE_OFF = 4'h8;

    // ------------------------------
    // Half periods of notes 0 to 11, in clocks
    // ------------------------------
    localparam logic [PERIOD_W-1:0] NOTE_BASE [12] = '{
        24'h2ea842, 24'h2c09e1, 24'h299120,
        24'h273be2, 24'h25082a, 24'h22f415,
        24'h20fdde, 24'h1f23d6, 24'h1d6469,
        24'h1bbe19, 24'h1a2f7d, 24'h18b740
    };

    // ------------------------------
    // Decimating lowpass filter
    // ------------------------------
    localparam int NUM_TAPS  = 32;
    localparam int TAP_W     = 5;
    localparam int ACC_W     = 48;
    localparam int COEF_FRAC = 15;

    // Tap k weights the sample of age k
    localparam sample_t FIR_COEF [NUM_TAPS] = '{
        18'h3fffe, 18'h3fffe, 18'h3ffff, 18'h00006,
        18'h00013, 18'h00027, 18'h00040, 18'h00058,
        18'h00065, 18'h0005b, 18'h0002b, 18'h3ffcc,
        18'h3ff3b, 18'h3fe82, 18'h3fdbc, 18'h3fd13,
        18'h3fcbe, 18'h3fcf9, 18'h3fdff, 18'h3fff7,
        18'h002f0, 18'h006d5, 18'h00b6a, 18'h01054,
        18'h0151b, 18'h01942, 18'h01c54, 18'h01df5,
        18'h01df5, 18'h01c54, 18'h01942, 18'h0151b
    };

endpackage

// ==== source/voice_if.sv ====
// Note event interface between the control module and the oscillator
`timescale 1ns/10ps

interface voice_if;

    logic                         note_on;
    logic                         note_off;
    logic [synth_pkg::NOTE_W-1:0] note;
    logic [synth_pkg::VEL_W-1:0]  velocity;

    modport source (
        output note_on, note_off, note, velocity
    );

    modport sink (
        input note_on, note_off, note, velocity
    );

endinterface

// ==== source/hist_if.sv ====
// FIR sample history write and read interface
`timescale 1ns/10ps

interface hist_if;

    logic                        wr_en;
    synth_pkg::sample_t          wr_data;
    logic [synth_pkg::TAP_W-1:0] rd_tap;
    synth_pkg::sample_t          rd_data;

    modport writer  (output wr_en, wr_data);

    modport reader  (output rd_tap, input rd_data);

    modport storage (input wr_en, wr_data, rd_tap, output rd_data);

endinterface

// ==== source/voice_ctrl.sv ====
// MIDI note decode, trigger counter, FIR request handshake and output strobe
`timescale 1ns/10ps

module voice_ctrl #(
    parameter int DECIM = 8
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             i_midi_rdy,
    input  logic [synth_pkg::MIDI_CMD_W-1:0] i_midi_cmd,
    input  logic [synth_pkg::NOTE_W-1:0]     i_midi_data0,
    input  logic [synth_pkg::VEL_W-1:0]      i_midi_data1,
    input  logic                             i_sample_8x_trig,
    voice_if.source                          voice,
    output logic                             o_req,
    input  logic                             i_ack,
    output logic                             o_sample_rdy
);

    localparam int CNT_W = (DECIM > 1) ? $clog2(DECIM) : 1;

    logic [CNT_W-1:0] trig_cnt;
    logic             decim_hit;
    logic             decim_d1;
    logic             ack_d1;

    // ------------------------------
    // MIDI decode
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            voice.note_on  <= 1'b0;
            voice.note_off <= 1'b0;
            voice.note     <= '0;
            voice.velocity <= '0;
        end else begin
            voice.note_on  <= i_midi_rdy && (i_midi_cmd == synth_pkg::MIDI_NOTE_ON);
            voice.note_off <= i_midi_rdy && (i_midi_cmd == synth_pkg::MIDI_NOTE_OFF);
            if (i_midi_rdy && (i_midi_cmd == synth_pkg::MIDI_NOTE_ON)) begin
                voice.note     <= i_midi_data0;
                voice.velocity <= i_midi_data1;
            end
        end
    end

    // ------------------------------
    // Decimation and FIR request
    // ------------------------------
    assign decim_hit = i_sample_8x_trig && (trig_cnt == CNT_W'(DECIM - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trig_cnt <= '0;
            decim_d1 <= 1'b0;
            o_req    <= 1'b0;
            ack_d1   <= 1'b0;
        end else begin
            if (decim_hit) begin
                trig_cnt <= '0;
            end else if (i_sample_8x_trig) begin
                trig_cnt <= trig_cnt + 1'b1;
            end
            // One cycle for the history write to land
            decim_d1 <= decim_hit;
            if (o_req && i_ack) begin
                o_req <= 1'b0;
            end else if (decim_d1 && !o_req && !i_ack) begin
                o_req <= 1'b1;
            end
            ack_d1 <= i_ack;
        end
    end

    // Strobe on the rising edge of ack
    assign o_sample_rdy = i_ack && !ack_d1;

endmodule

// ==== source/square_osc.sv ====
// Note period lookup, square level oscillator and one-pole smoother
`timescale 1ns/10ps

module square_osc (
    input  logic   clk,
    input  logic   reset,
    voice_if.sink  voice,
    input  logic   i_sample_8x_trig,
    hist_if.writer hist
);

    localparam int LEVEL_SHIFT = 9;

    logic [3:0]                     note_idx;
    logic [3:0]                     octave;
    logic [synth_pkg::PERIOD_W-1:0] note_period;
    logic [synth_pkg::PERIOD_W-1:0] half_period;
    logic [synth_pkg::PERIOD_W-1:0] period_cnt;
    logic                           sounding;
    synth_pkg::sample_t             level;
    synth_pkg::sample_t             smooth;
    logic signed [synth_pkg::SAMPLE_W:0] smooth_sum;

    // Lowest octave entry shifted down by octave number
    assign note_idx    = 4'(voice.note % 7'd12);
    assign octave      = 4'(voice.note / 7'd12);
    assign note_period = synth_pkg::NOTE_BASE[note_idx] >> octave;

    // ------------------------------
    // Oscillator
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            half_period <= '0;
            period_cnt  <= '0;
            sounding    <= 1'b0;
            level       <= '0;
        end else if (voice.note_on) begin
            half_period <= note_period;
            period_cnt  <= '0;
            sounding    <= 1'b1;
            level       <= {voice.velocity, {LEVEL_SHIFT{1'b0}}};
        end else if (voice.note_off) begin
            sounding <= 1'b0;
            level    <= '0;
        end else if (sounding) begin
            if (period_cnt == half_period) begin
                period_cnt <= '0;
                level      <= -level;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    // ------------------------------
    // Smoother at the 8x rate
    // ------------------------------
    assign smooth_sum = level + smooth;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            smooth     <= '0;
            hist.wr_en <= 1'b0;
        end else begin
            if (i_sample_8x_trig) begin
                smooth <= synth_pkg::sample_t'(smooth_sum >>> 1);
            end
            hist.wr_en <= i_sample_8x_trig;
        end
    end

    assign hist.wr_data = smooth;

endmodule

// ==== source/fir_history.sv ====
// Circular register buffer of the most recent smoothed samples
`timescale 1ns/10ps

module fir_history (
    input  logic    clk,
    input  logic    reset,
    hist_if.storage hist
);

    synth_pkg::sample_t          ring [synth_pkg::NUM_TAPS];
    logic [synth_pkg::TAP_W-1:0] wr_ptr;
    logic [synth_pkg::TAP_W-1:0] rd_idx;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            for (int i = 0; i < synth_pkg::NUM_TAPS; i++) begin
                ring[i] <= '0;
            end
        end else if (hist.wr_en) begin
            ring[wr_ptr] <= hist.wr_data;
            wr_ptr       <= wr_ptr + 1'b1;
        end
    end

    // Age 0 sits just behind the write pointer
    assign rd_idx       = wr_ptr - 1'b1 - hist.rd_tap;
    assign hist.rd_data = ring[rd_idx];

endmodule

// ==== source/fir_mac.sv ====
// FIR tap sequencer, multiply-accumulate and result register with ack side
`timescale 1ns/10ps

module fir_mac (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_req,
    output logic               o_ack,
    hist_if.reader             hist,
    output synth_pkg::sample_t o_result
);

    localparam int PROD_W = 2 * synth_pkg::SAMPLE_W;

    logic [synth_pkg::TAP_W-1:0]       tap;
    logic                              run;
    logic                              sum_done;
    synth_pkg::sample_t                coef;
    logic signed [PROD_W-1:0]          prod;
    logic signed [synth_pkg::ACC_W-1:0] prod_ext;
    logic signed [synth_pkg::ACC_W-1:0] acc;
    logic signed [synth_pkg::ACC_W-1:0] acc_scaled;

    // One tap per cycle while a request is open
    assign run = i_req && !o_ack && !sum_done;

    assign hist.rd_tap = tap;
    assign coef        = synth_pkg::FIR_COEF[tap];
    assign prod        = coef * hist.rd_data;
    assign prod_ext    = {{(synth_pkg::ACC_W - PROD_W){prod[PROD_W-1]}}, prod};
    assign acc_scaled  = acc >>> synth_pkg::COEF_FRAC;

    // ------------------------------
    // Sequencer and handshake
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tap      <= '0;
            sum_done <= 1'b0;
            o_ack    <= 1'b0;
            o_result <= '0;
        end else begin
            if (run) begin
                // Wraps back to tap 0 after the last one
                tap <= tap + 1'b1;
                if (tap == synth_pkg::TAP_W'(synth_pkg::NUM_TAPS - 1)) begin
                    sum_done <= 1'b1;
                end
            end
            if (sum_done) begin
                o_result <= acc_scaled[synth_pkg::SAMPLE_W-1:0];
                o_ack    <= 1'b1;
                sum_done <= 1'b0;
            end else if (o_ack && !i_req) begin
                o_ack <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Accumulator
    // ------------------------------
    always_ff @(posedge clk) begin
        if (run) begin
            if (tap == '0) begin
                acc <= prod_ext;
            end else begin
                acc <= acc + prod_ext;
            end
        end
    end

endmodule

// ==== source/pulse_voice_top.sv ====
// Pulse voice top level with control, oscillator, history and FIR MAC
`timescale 1ns/10ps

module pulse_voice_top #(
    parameter int DECIM = 8
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             i_midi_rdy,
    input  logic [synth_pkg::MIDI_CMD_W-1:0] i_midi_cmd,
    input  logic [synth_pkg::NOTE_W-1:0]     i_midi_data0,
    input  logic [synth_pkg::VEL_W-1:0]      i_midi_data1,
    input  logic                             i_sample_8x_trig,
    output logic                             o_sample_rdy,
    output synth_pkg::sample_t               o_sample
);

    logic fir_req;
    logic fir_ack;

    voice_if u_voice_if ();
    hist_if  u_hist_if ();

    voice_ctrl #(
        .DECIM (DECIM)
    ) u_voice_ctrl (
        .clk              (clk),
        .reset            (reset),
        .i_midi_rdy       (i_midi_rdy),
        .i_midi_cmd       (i_midi_cmd),
        .i_midi_data0     (i_midi_data0),
        .i_midi_data1     (i_midi_data1),
        .i_sample_8x_trig (i_sample_8x_trig),
        .voice            (u_voice_if.source),
        .o_req            (fir_req),
        .i_ack            (fir_ack),
        .o_sample_rdy     (o_sample_rdy)
    );

    square_osc u_square_osc (
        .clk              (clk),
        .reset            (reset),
        .voice            (u_voice_if.sink),
        .i_sample_8x_trig (i_sample_8x_trig),
        .hist             (u_hist_if.writer)
    );

    fir_history u_fir_history (
        .clk   (clk),
        .reset (reset),
        .hist  (u_hist_if.storage)
    );

    fir_mac u_fir_mac (
        .clk      (clk),
        .reset    (reset),
        .i_req    (fir_req),
        .o_ack    (fir_ack),
        .hist     (u_hist_if.reader),
        .o_result (o_sample)
    );

endmodule

// ==== testbench/tb_ref_model.svh ====
// Reference model of oscillator, smoother, history and FIR result, plus the LFSR
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0]                    lfsr_state;
logic                           m_note_on;
logic                           m_note_off;
logic [synth_pkg::NOTE_W-1:0]   m_note;
logic [synth_pkg::VEL_W-1:0]    m_vel;
logic [synth_pkg::PERIOD_W-1:0] m_half;
logic [synth_pkg::PERIOD_W-1:0] m_cnt;
logic                           m_sounding;
synth_pkg::sample_t             m_level;
synth_pkg::sample_t             m_smooth;
logic                           m_wr_en;
synth_pkg::sample_t             m_hist [synth_pkg::NUM_TAPS];

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
endfunction

function automatic logic [synth_pkg::PERIOD_W-1:0] period_of(input int note);
    return synth_pkg::NOTE_BASE[note % 12] >> (note / 12);
endfunction

// One clock edge, using the inputs held during the cycle before it
task automatic model_step(input logic midi_rdy, input logic [3:0] cmd,
                          input logic [6:0] data0, input logic [6:0] data1,
                          input logic trig);
    int sum;
    if (m_wr_en) begin
        for (int k = synth_pkg::NUM_TAPS - 1; k > 0; k--) begin
            m_hist[k] = m_hist[k-1];
        end
        m_hist[0] = m_smooth;
    end
    m_wr_en = trig;
    if (trig) begin
        sum = int'(m_level) + int'(m_smooth);
        m_smooth = synth_pkg::sample_t'(sum >>> 1);
    end
    if (m_note_on) begin
        m_half     = period_of(int'(m_note));
        m_cnt      = '0;
        m_sounding = 1'b1;
        m_level    = synth_pkg::sample_t'(int'(m_vel) * 512);
    end else if (m_note_off) begin
        m_sounding = 1'b0;
        m_level    = '0;
    end else if (m_sounding) begin
        if (m_cnt == m_half) begin
            m_cnt   = '0;
            m_level = -m_level;
        end else begin
            m_cnt = m_cnt + 1;
        end
    end
    m_note_on  = midi_rdy && (cmd == synth_pkg::MIDI_NOTE_ON);
    m_note_off = midi_rdy && (cmd == synth_pkg::MIDI_NOTE_OFF);
    if (m_note_on) begin
        m_note = data0;
        m_vel  = data1;
    end
endtask

function automatic synth_pkg::sample_t expected_fir();
    longint acc;
    acc = 0;
    for (int k = 0; k < synth_pkg::NUM_TAPS; k++) begin
        acc += longint'(synth_pkg::FIR_COEF[k]) * longint'(m_hist[k]);
    end
    return synth_pkg::sample_t'(acc >>> synth_pkg::COEF_FRAC);
endfunction

function automatic logic hist_all_zero();
    logic z;
    z = 1'b1;
    for (int k = 0; k < synth_pkg::NUM_TAPS; k++) begin
        z = z && (m_hist[k] == '0);
    end
    return z;
endfunction

`endif

// ==== testbench/tb_pulse_voice.sv ====
// Testbench for the pulse voice with clock, reset, stimulus and checks
`timescale 1ns/10ps

module tb_pulse_voice;

    localparam int DECIM = 8;

    logic               clk;
    logic               reset;
    logic               i_midi_rdy;
    logic [3:0]         i_midi_cmd;
    logic [6:0]         i_midi_data0;
    logic [6:0]         i_midi_data1;
    logic               i_sample_8x_trig;
    logic               o_sample_rdy;
    synth_pkg::sample_t o_sample;

    int   error_count;
    int   rdy_count;
    int   group_count;
    int   trig_total;
    logic out_pending;

    `include "tb_ref_model.svh"

    pulse_voice_top #(
        .DECIM (DECIM)
    ) u_pulse_voice_top (
        .clk              (clk),
        .reset            (reset),
        .i_midi_rdy       (i_midi_rdy),
        .i_midi_cmd       (i_midi_cmd),
        .i_midi_data0     (i_midi_data0),
        .i_midi_data1     (i_midi_data1),
        .i_sample_8x_trig (i_sample_8x_trig),
        .o_sample_rdy     (o_sample_rdy),
        .o_sample         (o_sample)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
        o_sample_rdy |=> !o_sample_rdy)
        else begin
            $display("ERROR at %0t: o_sample_rdy high for more than one cycle", $time);
            error_count++;
        end

    // ------------------------------
    // Checks, then model step for the coming edge
    // ------------------------------
    always @(negedge clk) begin
        if (!reset) begin
            if (trig_total == 0) begin
                assert (!o_sample_rdy && o_sample == '0)
                else begin
                    $display("ERROR at %0t: output active before any trigger", $time);
                    error_count++;
                end
            end
            if (o_sample_rdy) begin
                assert (out_pending)
                else begin
                    $display("ERROR at %0t: o_sample_rdy without a full trigger group", $time);
                    error_count++;
                end
                assert (o_sample == expected_fir())
                else begin
                    $display("ERROR at %0t: o_sample %0d, expected %0d",
                             $time, o_sample, expected_fir());
                    error_count++;
                end
                if (hist_all_zero()) begin
                    assert (o_sample == '0)
                    else begin
                        $display("ERROR at %0t: o_sample %0d on silent history", $time, o_sample);
                        error_count++;
                    end
                end
                rdy_count++;
                out_pending = 1'b0;
            end
            if (i_sample_8x_trig) begin
                trig_total++;
                if (trig_total % DECIM == 0) begin
                    assert (!out_pending)
                    else begin
                        $display("ERROR at %0t: previous output sample never came", $time);
                        error_count++;
                    end
                    out_pending = 1'b1;
                    group_count++;
                end
            end
            model_step(i_midi_rdy, i_midi_cmd, i_midi_data0, i_midi_data1, i_sample_8x_trig);
        end
    end

    task automatic send_midi(input logic [3:0] cmd, input int note, input int vel);
        @(posedge clk);
        i_midi_rdy   <= 1'b1;
        i_midi_cmd   <= cmd;
        i_midi_data0 <= 7'(note);
        i_midi_data1 <= 7'(vel);
        @(posedge clk);
        i_midi_rdy   <= 1'b0;
    endtask

    task automatic send_trigger();
        int gap;
        gap = 40 + rand_bits(3);
        repeat (gap) @(posedge clk);
        i_sample_8x_trig <= 1'b1;
        @(posedge clk);
        i_sample_8x_trig <= 1'b0;
    endtask

    task automatic run_groups(input int n);
        int cycles;
        for (int g = 0; g < n; g++) begin
            repeat (DECIM) send_trigger();
            cycles = 0;
            while (rdy_count < group_count && cycles < 200) begin
                @(posedge clk);
                cycles++;
            end
            if (rdy_count < group_count) begin
                $display("Timeout: no output sample after trigger group %0d", group_count);
                error_count++;
            end
        end
    endtask

    initial begin
        int first_note;
        int second_note;
        int tries;
        error_count      = 0;
        rdy_count        = 0;
        group_count      = 0;
        trig_total       = 0;
        out_pending      = 1'b0;
        lfsr_state       = 32'h5542a752;
        reset            = 1'b1;
        i_midi_rdy       = 1'b0;
        i_midi_cmd       = '0;
        i_midi_data0     = '0;
        i_midi_data1     = '0;
        i_sample_8x_trig = 1'b0;
        model_clear();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (20) @(posedge clk);
        run_groups(3);
        // Top notes keep half periods within a few thousand clocks
        first_note = 112 + rand_bits(4);
        send_midi(synth_pkg::MIDI_NOTE_ON, first_note, 64 + rand_bits(6));
        run_groups(12);
        second_note = 112 + (first_note - 112 + 1 + rand_bits(3)) % 16;
        send_midi(synth_pkg::MIDI_NOTE_ON, second_note, 32 + rand_bits(6));
        run_groups(12);
        // Positive smoothed value decays to exactly zero
        tries = 0;
        while (!(m_level > 0 && m_smooth > 0) && tries < 50) begin
            run_groups(1);
            tries++;
        end
        if (!(m_level > 0 && m_smooth > 0)) begin
            $display("Timeout: level never turned positive before note-off");
            error_count++;
        end
        send_midi(synth_pkg::MIDI_NOTE_OFF, second_note, 0);
        run_groups(10);
        assert (rdy_count == group_count)
        else begin
            $display("ERROR at %0t: %0d outputs for %0d groups", $time, rdy_count, group_count);
            error_count++;
        end
        // Silent again once the decay has left the history
        assert (o_sample == '0)
        else begin
            $display("ERROR at %0t: o_sample %0d after decay, expected 0", $time, o_sample);
            error_count++;
        end
        $display("Summary: %0d triggers, %0d samples checked, %0d errors",
                 trig_total, rdy_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    task automatic model_clear();
        m_note_on  = 1'b0;
        m_note_off = 1'b0;
        m_note     = '0;
        m_vel      = '0;
        m_half     = '0;
        m_cnt      = '0;
        m_sounding = 1'b0;
        m_level    = '0;
        m_smooth   = '0;
        m_wr_en    = 1'b0;
        for (int k = 0; k < synth_pkg::NUM_TAPS; k++) begin
            m_hist[k] = '0;
        end
    endtask

endmodule

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pulse_voice
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard testbench/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src.f ====
+incdir+testbench
source/synth_pkg.sv
source/voice_if.sv
source/hist_if.sv
source/voice_ctrl.sv
source/square_osc.sv
source/fir_history.sv
source/fir_mac.sv
source/pulse_voice_top.sv
testbench/tb_pulse_voice.sv
